// File: hw/cpuPkg.sv
`default_nettype none

package cpuPkg;

    // ==================================================
    // Field widths and data types
    // ==================================================
    localparam int InstrWidth = 16;
    localparam int RegBytes   = 4;

    typedef logic [5:0]              opcodeT;
    typedef logic [1:0]              regSelT;
    typedef logic [7:0]              byteT;
    typedef logic [7:0]              offsetT;   // Address or offset field
    typedef logic [RegBytes*8-1:0]   regWordT;

    // Supported opcodes, everything else runs as a no-op
    localparam opcodeT OpLdal  = 6'h1E;
    localparam opcodeT OpLdah  = 6'h1F;
    localparam opcodeT OpSta   = 6'h20;
    localparam opcodeT OpStrim = 6'h24;

    // ==================================================
    // One-hot timing states
    // ==================================================
    typedef logic [8:0] tStateT;

    localparam tStateT T0 = 9'b0_0000_0001;
    localparam tStateT T1 = 9'b0_0000_0010;
    localparam tStateT T2 = 9'b0_0000_0100;
    localparam tStateT T3 = 9'b0_0000_1000;
    localparam tStateT T4 = 9'b0_0001_0000;
    localparam tStateT T5 = 9'b0_0010_0000;
    localparam tStateT T6 = 9'b0_0100_0000;
    localparam tStateT T7 = 9'b0_1000_0000;
    localparam tStateT T8 = 9'b1_0000_0000;

    typedef struct packed {
        logic       pcInc;
        logic       arLoadField;
        logic       arInc;
        logic       arAddOffset;
        logic       scratchLoad;
        logic       drLoadByte;
        logic       drClear;       // With regLoad: zero-extend halfword, then clear DR
        logic       regLoad;
        logic       addrFromAr;    // Bus address from AR instead of PC
        logic [1:0] storeByteSel;
    } ctrlT;

endpackage

`default_nettype wire

// File: hw/memAccessIf.sv
`timescale 1ns/1ps
`default_nettype none

interface memAccessIf #(
    parameter int AddrWidth = 8
);
    import cpuPkg::*;

    logic                 req;     // Held until done
    logic                 we;
    logic [AddrWidth-1:0] addr;
    byteT                 wrData;
    byteT                 rdData;  // Valid during done
    logic                 done;    // One-cycle pulse

    modport sequencer (output req, output we, input done, input rdData);

    modport addrSource (output addr);

    modport dataSource (output wrData, input rdData);

    modport master (
        input  req,
        input  we,
        input  addr,
        input  wrData,
        output rdData,
        output done
    );

endinterface

`default_nettype wire

// File: hw/wbByteMaster.sv
`timescale 1ns/1ps
`default_nettype none

module wbByteMaster #(
    parameter int AddrWidth = 8
) (
    input  logic                 Clock,
    input  logic                 Reset,
    memAccessIf.master           mem,
    output logic                 busCyc,
    output logic                 busStb,
    output logic                 busWe,
    output logic [AddrWidth-1:0] busAdr,
    output cpuPkg::byteT         busDatWr,
    input  cpuPkg::byteT         busDatRd,
    input  logic                 busAck
);

    logic startCycle;
    logic ackSeen;

    // No new cycle while one is open or its done pulse is out
    assign startCycle = mem.req && !busCyc && !mem.done;
    assign ackSeen    = busCyc && busStb && busAck;

    always_ff @(posedge Clock or posedge Reset) begin
        if (Reset) begin
            busCyc   <= 1'b0;
            busStb   <= 1'b0;
            busWe    <= 1'b0;
            mem.done <= 1'b0;
        end else begin
            mem.done <= 1'b0;
            if (ackSeen) begin
                busCyc   <= 1'b0;
                busStb   <= 1'b0;
                busWe    <= 1'b0;
                mem.done <= 1'b1;           // Same cycle the strobe drops
            end else if (startCycle) begin
                busCyc <= 1'b1;
                busStb <= 1'b1;
                busWe  <= mem.we;
            end
        end
    end

    always_ff @(posedge Clock) begin
        if (startCycle) begin
            busAdr   <= mem.addr;           // Held for the whole cycle
            busDatWr <= mem.wrData;
        end
        if (ackSeen) begin
            mem.rdData <= busDatRd;
        end
    end

    // ==================================================
    // Bus protocol checks
    // ==================================================
    stbInsideCyc: assert property (@(posedge Clock) disable iff (Reset)
        busStb |-> busCyc);

    adrStableUntilAck: assert property (@(posedge Clock) disable iff (Reset)
        (busStb && !busAck) |=> $stable(busAdr));

endmodule

`default_nettype wire

// File: hw/controlSequencer.sv
`timescale 1ns/1ps
`default_nettype none

module controlSequencer (
    input  logic           Clock,
    input  logic           Reset,
    memAccessIf.sequencer  mem,
    output cpuPkg::ctrlT   ctrl,
    output cpuPkg::regSelT regSel,
    output cpuPkg::offsetT field
);
    import cpuPkg::*;

    tStateT                state;
    tStateT                stateNext;
    logic [InstrWidth-1:0] ir;
    opcodeT                opcode;
    ctrlT                  ctrlRaw;
    logic                  access;       // State waits for a bus access
    logic                  writeAccess;
    logic                  lastState;
    logic                  irLowLoad;
    logic                  irHighLoad;
    logic                  advance;
    logic [3:0]            stateIdx;

    function automatic logic isSupported(opcodeT op);
        return op inside {OpLdal, OpLdah, OpSta, OpStrim};
    endfunction

    function automatic logic [3:0] stateIndex(tStateT s);
        logic [3:0] idx;
        idx = '0;
        for (int i = 0; i < $bits(tStateT); i++) begin
            if (s[i]) begin
                idx = 4'(i);
            end
        end
        return idx;
    endfunction

    assign stateIdx = stateIndex(state);

    // ==================================================
    // Per-state control
    // ==================================================
    always_comb begin
        ctrlRaw     = '0;
        access      = 1'b0;
        writeAccess = 1'b0;
        lastState   = 1'b0;
        irLowLoad   = 1'b0;
        irHighLoad  = 1'b0;
        case (state)
            T0: begin
                access        = 1'b1;
                irLowLoad     = 1'b1;
                ctrlRaw.pcInc = 1'b1;
            end
            T1: begin
                access     = 1'b1;
                irHighLoad = 1'b1;
            end
            T2: begin
                ctrlRaw.pcInc = 1'b1;
                lastState     = !isSupported(ir[15:10]);  // No-op ends here
            end
            default: begin
                case (opcode)
                    OpLdal, OpLdah: begin
                        if (state == T3) begin
                            ctrlRaw.arLoadField = 1'b1;
                        end else if ((opcode == OpLdal && state == T6) || state == T8) begin
                            ctrlRaw.regLoad = 1'b1;
                            ctrlRaw.drClear = (opcode == OpLdal);
                            lastState       = 1'b1;
                        end else begin
                            access             = 1'b1;
                            ctrlRaw.addrFromAr = 1'b1;
                            ctrlRaw.drLoadByte = 1'b1;
                            // No increment after the last byte
                            ctrlRaw.arInc = !((opcode == OpLdal && state == T5) || state == T7);
                        end
                    end
                    OpSta: begin
                        if (state == T3) begin
                            ctrlRaw.arLoadField = 1'b1;
                        end else begin
                            access               = 1'b1;
                            writeAccess          = 1'b1;
                            ctrlRaw.addrFromAr   = 1'b1;
                            ctrlRaw.storeByteSel = 2'(stateIdx - 4'd4);
                            ctrlRaw.arInc        = (state != T7);
                            lastState            = (state == T7);
                        end
                    end
                    OpStrim: begin
                        if (state == T3) begin
                            ctrlRaw.scratchLoad = 1'b1;
                        end else if (state == T4) begin
                            ctrlRaw.arAddOffset = 1'b1;  // AR + offset
                        end else begin
                            access               = 1'b1;
                            writeAccess          = 1'b1;
                            ctrlRaw.addrFromAr   = 1'b1;
                            ctrlRaw.storeByteSel = 2'(stateIdx - 4'd5);
                            ctrlRaw.arInc        = (state != T8);
                            lastState            = (state == T8);
                        end
                    end
                    default: lastState = 1'b1;
                endcase
            end
        endcase
    end

    assign advance     = access ? mem.done : 1'b1;
    assign mem.req     = access;
    assign mem.we      = writeAccess;
    assign stateNext   = !advance ? state :
                         lastState ? T0 : {state[7:0], state[8]};

    // Enables fire only on the cycle the state moves on
    always_comb begin
        ctrl = ctrlRaw;
        if (!advance) begin
            ctrl.pcInc       = 1'b0;
            ctrl.arLoadField = 1'b0;
            ctrl.arInc       = 1'b0;
            ctrl.arAddOffset = 1'b0;
            ctrl.scratchLoad = 1'b0;
            ctrl.drLoadByte  = 1'b0;
            ctrl.drClear     = 1'b0;
            ctrl.regLoad     = 1'b0;
        end
    end

    always_ff @(posedge Clock or posedge Reset) begin
        if (Reset) begin
            state  <= T0;
            opcode <= '0;
            regSel <= '0;
            field  <= '0;
        end else begin
            state <= stateNext;
            if (state == T2) begin        // Decode
                opcode <= ir[15:10];
                regSel <= ir[9:8];
                field  <= ir[7:0];
            end
        end
    end

    always_ff @(posedge Clock) begin
        if (irLowLoad && advance) begin
            ir[InstrWidth/2-1:0] <= mem.rdData;
        end
        if (irHighLoad && advance) begin
            ir[InstrWidth-1:InstrWidth/2] <= mem.rdData;
        end
    end

    stateOneHot: assert property (@(posedge Clock) disable iff (Reset)
        $onehot(state));

endmodule

`default_nettype wire

// File: hw/addressRegisters.sv
`timescale 1ns/1ps
`default_nettype none

module addressRegisters #(
    parameter int AddrWidth = 8
) (
    input  logic           Clock,
    input  logic           Reset,
    input  cpuPkg::ctrlT   ctrl,
    input  cpuPkg::offsetT field,
    memAccessIf.addrSource mem
);
    import cpuPkg::*;

    logic [AddrWidth-1:0] pc;
    logic [AddrWidth-1:0] ar;
    logic [AddrWidth-1:0] arSum;
    offsetT               scratch;   // STRIM offset

    // Wraps modulo 2**AddrWidth
    assign arSum = ar + AddrWidth'(scratch);

    // ==================================================
    // Program counter and address register
    // ==================================================
    always_ff @(posedge Clock or posedge Reset) begin
        if (Reset) begin
            pc <= '0;
        end else if (ctrl.pcInc) begin
            pc <= pc + 1'b1;
        end
    end

    always_ff @(posedge Clock or posedge Reset) begin
        if (Reset) begin
            ar <= '0;
        end else begin
            if (ctrl.arLoadField) begin
                ar <= AddrWidth'(field);   // Zero-extended
            end else if (ctrl.arAddOffset) begin
                ar <= arSum;
            end else if (ctrl.arInc) begin
                ar <= ar + 1'b1;
            end
        end
    end

    always_ff @(posedge Clock) begin
        if (ctrl.scratchLoad) begin
            scratch <= field;
        end
    end

    assign mem.addr = ctrl.addrFromAr ? ar : pc;

endmodule

`default_nettype wire

// File: hw/registerFile.sv
`timescale 1ns/1ps
`default_nettype none

module registerFile (
    input  logic           Clock,
    input  logic           Reset,
    input  cpuPkg::ctrlT   ctrl,
    input  cpuPkg::regSelT regSel,
    memAccessIf.dataSource mem
);
    import cpuPkg::*;

    localparam int NumRegs = 2 ** $bits(regSelT);

    regWordT regs [NumRegs];
    regWordT dr;            // Byte-assembling data register
    regWordT loadWord;
    regWordT storeWord;

    // Halfword loads sit in the top half after two shifts
    assign loadWord = ctrl.drClear ? regWordT'(dr[RegBytes*8-1:RegBytes*4]) : dr;

    // ==================================================
    // Data register and general registers
    // ==================================================
    always_ff @(posedge Clock or posedge Reset) begin
        if (Reset) begin
            dr <= '0;
        end else if (ctrl.drClear) begin
            dr <= '0;
        end else if (ctrl.drLoadByte) begin
            dr <= {mem.rdData, dr[RegBytes*8-1:8]};  // Shift in from the top
        end
    end

    always_ff @(posedge Clock or posedge Reset) begin
        if (Reset) begin
            for (int i = 0; i < NumRegs; i++) begin
                regs[i] <= '0;
            end
        end else if (ctrl.regLoad) begin
            regs[regSel] <= loadWord;
        end
    end

    // Little-endian store, byte 0 first
    assign storeWord  = regs[regSel];
    assign mem.wrData = storeWord[ctrl.storeByteSel*8 +: 8];

    noLoadDuringShift: assert property (@(posedge Clock) disable iff (Reset)
        !(ctrl.regLoad && ctrl.drLoadByte));

endmodule

`default_nettype wire

// File: hw/multiCycleCpu.sv
`timescale 1ns/1ps
`default_nettype none

module multiCycleCpu #(
    parameter int AddrWidth = 8
) (
    input  logic                 Clock,
    input  logic                 Reset,
    output logic                 busCyc,
    output logic                 busStb,
    output logic                 busWe,
    output logic [AddrWidth-1:0] busAdr,
    output cpuPkg::byteT         busDatWr,
    input  cpuPkg::byteT         busDatRd,
    input  logic                 busAck
);
    import cpuPkg::*;

    ctrlT   ctrl;
    regSelT regSel;
    offsetT field;

    memAccessIf #(.AddrWidth(AddrWidth)) memBus ();

    wbByteMaster #(.AddrWidth(AddrWidth)) wbByteMaster_i (
        .Clock    (Clock),
        .Reset    (Reset),
        .mem      (memBus.master),
        .busCyc   (busCyc),
        .busStb   (busStb),
        .busWe    (busWe),
        .busAdr   (busAdr),
        .busDatWr (busDatWr),
        .busDatRd (busDatRd),
        .busAck   (busAck)
    );

    controlSequencer controlSequencer_i (
        .Clock  (Clock),
        .Reset  (Reset),
        .mem    (memBus.sequencer),
        .ctrl   (ctrl),
        .regSel (regSel),
        .field  (field)
    );

    addressRegisters #(.AddrWidth(AddrWidth)) addressRegisters_i (
        .Clock (Clock),
        .Reset (Reset),
        .ctrl  (ctrl),
        .field (field),
        .mem   (memBus.addrSource)
    );

    registerFile registerFile_i (
        .Clock  (Clock),
        .Reset  (Reset),
        .ctrl   (ctrl),
        .regSel (regSel),
        .mem    (memBus.dataSource)
    );

endmodule

`default_nettype wire

// File: tb/clockGen.sv
`timescale 1ns/1ps
`default_nettype none

module clockGen #(
    parameter int HalfPeriod  = 20,
    parameter int ResetCycles = 3,
    parameter int DriveDelay  = 1
) (
    output logic Clock,
    output logic Reset
);

    initial begin
        Clock = 1'b0;
        Reset = 1'b1;                  // Held until the first test lets go
        forever begin
            #(HalfPeriod);
            Clock = ~Clock;
        end
    end

    task automatic assertReset();
        @(posedge Clock);
        #(DriveDelay);
        Reset = 1'b1;
    endtask

    task automatic releaseReset();
        repeat (ResetCycles) @(posedge Clock);
        #(DriveDelay);
        Reset = 1'b0;
    endtask

endmodule

`default_nettype wire

// File: tb/wbMemory.sv
`timescale 1ns/1ps
`default_nettype none

module wbMemory #(
    parameter int DriveDelay = 1
) (
    input  logic         Clock,
    input  logic         Reset,
    input  logic         busCyc,
    input  logic         busStb,
    input  logic         busWe,
    input  logic [7:0]   busAdr,
    input  cpuPkg::byteT busDatWr,
    output cpuPkg::byteT busDatRd,
    output logic         busAck
);
    import cpuPkg::*;

    byteT       mem [256];
    logic [7:0] accAddr [$];       // Every access, in order
    logic [7:0] wrAddr [$];
    byteT       wrData [$];
    int         minWait = 0;
    int         maxWait = 3;
    int         unstableCount = 0; // Address moved during wait states
    int         waitLeft = 0;
    int         waitsNow;
    logic       busy = 1'b0;
    logic [7:0] startAdr;
    byteT       rdByte;

    task automatic clearAll();
        for (int a = 0; a < 256; a++) begin
            mem[a] = '0;
        end
        accAddr.delete();
        wrAddr.delete();
        wrData.delete();
        unstableCount = 0;
    endtask

    // ==================================================
    // Wishbone classic slave, sampled at the edge
    // ==================================================
    initial begin
        busAck   = 1'b0;
        busDatRd = '0;
        forever begin
            @(posedge Clock);
            if (Reset) begin
                busy = 1'b0;
                #(DriveDelay);
                busAck = 1'b0;
            end else if (busAck) begin
                #(DriveDelay);
                busAck = 1'b0;        // Master has seen it
            end else if (busCyc && busStb) begin
                if (!busy) begin
                    waitsNow = minWait + int'($urandom % (maxWait - minWait + 1));
                    startAdr = busAdr;
                    accAddr.push_back(busAdr);
                end else begin
                    waitsNow = waitLeft;
                    if (busAdr != startAdr) begin
                        unstableCount++;
                    end
                end
                if (waitsNow == 0) begin
                    busy   = 1'b0;
                    rdByte = mem[busAdr];
                    if (busWe) begin
                        mem[busAdr] = busDatWr;
                        wrAddr.push_back(busAdr);
                        wrData.push_back(busDatWr);
                    end
                    #(DriveDelay);
                    busDatRd = rdByte;
                    busAck   = 1'b1;
                end else begin
                    busy     = 1'b1;
                    waitLeft = waitsNow - 1;
                end
            end
        end
    end

endmodule

`default_nettype wire

// File: tb/multiCycleCpuTb.sv
`timescale 1ns/1ps
`default_nettype none

module multiCycleCpuTb;
    import cpuPkg::*;

    localparam int AddrWidth     = 8;
    localparam int DriveDelay    = 1;
    localparam int TimeoutCycles = 2000;

    logic                 Clock;
    logic                 Reset;
    logic                 busCyc;
    logic                 busStb;
    logic                 busWe;
    logic [AddrWidth-1:0] busAdr;
    byteT                 busDatWr;
    byteT                 busDatRd;
    logic                 busAck;

    int         errorCount;
    int         testCount;
    int         failedTests;
    int         testErrors;
    logic [7:0] expAddr [$];
    byteT       expData [$];

    clockGen #(.HalfPeriod(20), .ResetCycles(3), .DriveDelay(DriveDelay)) clockGen_i (
        .Clock (Clock),
        .Reset (Reset)
    );

    wbMemory #(.DriveDelay(DriveDelay)) memory_i (
        .Clock    (Clock),
        .Reset    (Reset),
        .busCyc   (busCyc),
        .busStb   (busStb),
        .busWe    (busWe),
        .busAdr   (busAdr),
        .busDatWr (busDatWr),
        .busDatRd (busDatRd),
        .busAck   (busAck)
    );

    multiCycleCpu #(.AddrWidth(AddrWidth)) multiCycleCpu_i (
        .Clock    (Clock),
        .Reset    (Reset),
        .busCyc   (busCyc),
        .busStb   (busStb),
        .busWe    (busWe),
        .busAdr   (busAdr),
        .busDatWr (busDatWr),
        .busDatRd (busDatRd),
        .busAck   (busAck)
    );

    // ==================================================
    // Program images and expected stores
    // ==================================================
    task automatic putInstr(logic [7:0] addr, opcodeT op, regSelT r, offsetT f);
        memory_i.mem[addr]               = f;        // Field byte first
        memory_i.mem[8'(addr + 8'd1)]    = {op, r};
    endtask

    task automatic putWord(logic [7:0] addr, regWordT w);
        for (int i = 0; i < RegBytes; i++) begin
            memory_i.mem[8'(addr + i)] = w[i*8 +: 8];   // Little-endian
        end
    endtask

    task automatic expectStore(logic [7:0] addr, regWordT w);
        for (int i = 0; i < RegBytes; i++) begin
            expAddr.push_back(8'(addr + i));
            expData.push_back(w[i*8 +: 8]);
        end
    endtask

    task automatic beginTest();
        clockGen_i.assertReset();
        memory_i.clearAll();                  // Loaded while the CPU is held
        expAddr.delete();
        expData.delete();
        testErrors = 0;
    endtask

    task automatic waitLog(int n, bit writesOnly);
        int cycles;
        int got;
        cycles = 0;
        got    = writesOnly ? memory_i.wrAddr.size() : memory_i.accAddr.size();
        while (got < n && cycles < TimeoutCycles) begin
            @(posedge Clock);
            cycles++;
            got = writesOnly ? memory_i.wrAddr.size() : memory_i.accAddr.size();
        end
        assert (got >= n) else begin
            $display("Timeout after %0d cycles: %0d of %0d bus accesses logged",
                     cycles, got, n);
            testErrors++;
        end
    endtask

    task automatic checkWrites();
        waitLog(expAddr.size(), 1'b1);
        for (int i = 0; i < expAddr.size() && i < memory_i.wrAddr.size(); i++) begin
            assert (memory_i.wrAddr[i] == expAddr[i]) else begin
                $display("Error at %0t: busAdr of write %0d = %h, expected %h",
                         $time, i, memory_i.wrAddr[i], expAddr[i]);
                testErrors++;
            end
            assert (memory_i.wrData[i] == expData[i]) else begin
                $display("Error at %0t: busDatWr of write %0d = %h, expected %h",
                         $time, i, memory_i.wrData[i], expData[i]);
                testErrors++;
            end
        end
        assert (memory_i.unstableCount == 0) else begin
            $display("Bus address changed before its acknowledge %0d times",
                     memory_i.unstableCount);
            testErrors++;
        end
    endtask

    task automatic endTest(string name);
        testCount++;
        errorCount += testErrors;
        if (testErrors != 0) begin
            failedTests++;
        end
        $display("Test %-16s %s (%0d errors)", name, testErrors == 0 ? "ok" : "FAILED",
                 testErrors);
    endtask

    // ==================================================
    // Directed tests
    // ==================================================
    task automatic fetchAfterReset();
        beginTest();
        clockGen_i.releaseReset();
        assert (!busCyc && !busStb && !busWe) else begin
            $display("Error at %0t: {busCyc,busStb,busWe} = %b, expected 000",
                     $time, {busCyc, busStb, busWe});
            testErrors++;
        end
        waitLog(4, 1'b0);                     // Two no-op instructions
        for (int i = 0; i < 4 && i < memory_i.accAddr.size(); i++) begin
            assert (memory_i.accAddr[i] == 8'(i)) else begin
                $display("Error at %0t: busAdr of access %0d = %h, expected %h",
                         $time, i, memory_i.accAddr[i], 8'(i));
                testErrors++;
            end
        end
        assert (memory_i.wrAddr.size() == 0) else begin
            $display("A write appeared while fetching no-op instructions");
            testErrors++;
        end
        endTest("resetFetch");
    endtask

    task automatic ldalThenSta();
        regWordT junk;
        regWordT data;
        beginTest();
        junk = $urandom;
        data = $urandom;
        putWord(8'h44, junk);
        putWord(8'h40, data);
        putInstr(8'h00, OpLdah, 2'd1, 8'h44);  // Upper half must be cleared later
        putInstr(8'h02, OpLdal, 2'd1, 8'h40);
        putInstr(8'h04, OpSta, 2'd1, 8'h60);
        expectStore(8'h60, {16'h0000, data[15:0]});
        clockGen_i.releaseReset();
        checkWrites();
        endTest("ldalSta");
    endtask

    task automatic allRegsRoundTrip();
        regWordT words [4];
        beginTest();
        for (int r = 0; r < 4; r++) begin
            words[r] = $urandom;
            putWord(8'(8'h40 + 4*r), words[r]);
            putInstr(8'(2*r), OpLdah, regSelT'(r), 8'(8'h40 + 4*r));
            putInstr(8'(8 + 2*r), OpSta, regSelT'(r), 8'(8'h80 + 4*r));
            expectStore(8'(8'h80 + 4*r), words[r]);
        end
        clockGen_i.releaseReset();
        checkWrites();
        endTest("allRegs");
    endtask

    task automatic strimOffsetStore();
        regWordT    data;
        logic [7:0] base;
        logic [7:0] offset;
        beginTest();
        data   = $urandom;
        base   = 8'(8'h80 + $urandom % 8'h70);
        offset = 8'(8'h90 + $urandom % 8'h60);  // Sum always passes 0xFF
        putWord(8'h40, data);
        putInstr(8'h00, OpLdah, 2'd2, 8'h40);
        putInstr(8'h02, OpSta, 2'd2, base);
        putInstr(8'h04, OpStrim, 2'd2, offset);
        expectStore(base, data);
        expectStore(8'(base + 3 + offset), data);   // AR left on last stored byte
        clockGen_i.releaseReset();
        checkWrites();
        endTest("strim");
    endtask

    task automatic unsupportedOpcode();
        regWordT data;
        beginTest();
        data = $urandom;
        putWord(8'h40, data);
        putInstr(8'h00, OpLdah, 2'd3, 8'h40);
        putInstr(8'h02, 6'h21, 2'd3, 8'h50);   // Not a supported opcode
        putInstr(8'h04, OpSta, 2'd3, 8'h90);
        expectStore(8'h90, data);
        clockGen_i.releaseReset();
        checkWrites();
        endTest("unsupported");
    endtask

    task automatic backPressure();
        regWordT    wordA;
        regWordT    wordB;
        logic [7:0] base;
        logic [7:0] offset;
        beginTest();
        memory_i.minWait = 1;                  // Every access waits
        wordA  = $urandom;
        wordB  = $urandom;
        base   = 8'(8'h80 + $urandom % 8'h20);
        offset = 8'($urandom % 8'h40);         // Keeps stores clear of the program
        putWord(8'h40, wordA);
        putWord(8'h48, wordB);
        putInstr(8'h00, OpLdah, 2'd0, 8'h40);
        putInstr(8'h02, OpLdal, 2'd1, 8'h48);
        putInstr(8'h04, OpSta, 2'd0, base);
        putInstr(8'h06, OpStrim, 2'd0, offset);
        putInstr(8'h08, OpSta, 2'd1, 8'h70);
        expectStore(base, wordA);
        expectStore(8'(base + 3 + offset), wordA);
        expectStore(8'h70, {16'h0000, wordB[15:0]});
        clockGen_i.releaseReset();
        checkWrites();
        memory_i.minWait = 0;
        endTest("backPressure");
    endtask

    initial begin
        void'($urandom(47));
        errorCount  = 0;
        testCount   = 0;
        failedTests = 0;
        fetchAfterReset();
        ldalThenSta();
        allRegsRoundTrip();
        strimOffsetStore();
        unsupportedOpcode();
        backPressure();
        $display("%0d tests run, %0d failed, %0d check errors",
                 testCount, failedTests, errorCount);
        if (errorCount == 0) begin
            $display("Simulation passed");
        end else begin
            $display("Simulation failed");
        end
        $finish;
    end

endmodule

`default_nettype wire

// File: vlog.f
hw/cpuPkg.sv
hw/memAccessIf.sv
hw/wbByteMaster.sv
hw/controlSequencer.sv
hw/addressRegisters.sv
hw/registerFile.sv
hw/multiCycleCpu.sv
tb/clockGen.sv
tb/wbMemory.sv
tb/multiCycleCpuTb.sv

// File: run.sh
#!/bin/sh
# Compile with Verilator, run the testbench, then search the log for the pass line
cd "$(dirname "$0")" || exit 1
rm -f sim.log

verilator --binary --timing --assert -f vlog.f --top-module multiCycleCpuTb -o simv \
    && ./obj_dir/simv 2>&1 | tee sim.log \
    || echo "Build or run step returned an error"

grep -qx "Simulation passed" sim.log && exit 0 || exit 1
